// File: memsys_pkg.sv
package memsys_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int DATA_W = 32;            // bus and memory word
    localparam int ADDR_W = 16;            // apb byte address
    localparam int STRB_W = DATA_W / 8;    // one strobe per byte lane

    // ------------------------------------------------------------------------
    // apb completer port
    // ------------------------------------------------------------------------
    // requester side, held stable from setup to completion
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
        logic [STRB_W-1:0] pstrb;
    } apb_req_t;

    // completer side
    typedef struct packed {
        logic              pready;
        logic              pslverr;
        logic [DATA_W-1:0] prdata;     // zero unless a read completes
    } apb_rsp_t;

    // ------------------------------------------------------------------------
    // internal
    // ------------------------------------------------------------------------
    // one bank command, enables active low like the bram
    typedef struct packed {
        logic              we_n;
        logic              re_n;
        logic [STRB_W-1:0] be;         // byte lanes to write
        logic [ADDR_W-1:0] addr;       // word index, bank takes low bits
        logic [DATA_W-1:0] wdata;
    } bank_cmd_t;

    // decoder to merger, valid in the access phase
    typedef struct packed {
        logic start;                   // first access cycle
        logic rd;                      // read transfer
        logic bank;                    // 0 program, 1 data
        logic err;                     // misaligned or out of range
    } xfer_info_t;

endpackage

// File: mem_bank.sv
`timescale 1ns/1ps

// word addressed block ram, one per region
// write and read enables active low, read data registered

module mem_bank #(
    parameter int WORDS = 10                        // log2 of words in the bank
) (
    input  logic                              clk_i,
    input  memsys_pkg::bank_cmd_t             cmd_i,
    output logic [memsys_pkg::DATA_W-1:0]     data_o  // holds when re_n is high
);

    localparam int DEPTH = 1 << WORDS;
    localparam int LANES = memsys_pkg::STRB_W;

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------
    logic [memsys_pkg::DATA_W-1:0] mem [DEPTH];     // no init, contents random

    logic [WORDS-1:0] idx;

    assign idx = cmd_i.addr[WORDS-1:0];             // upper addr bits ignored here

    // ------------------------------------------------------------------------
    // write port
    // ------------------------------------------------------------------------
    // each lane lands only with its strobe set
    always_ff @(posedge clk_i) begin
        if (!cmd_i.we_n) begin
            for (int b = 0; b < LANES; b++) begin
                if (cmd_i.be[b]) begin
                    mem[idx][b*8 +: 8] <= cmd_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // read port
    // ------------------------------------------------------------------------
    // one cycle latency, old word on a same-cycle write (not issued by decoder)
    always_ff @(posedge clk_i) begin
        if (!cmd_i.re_n) begin
            data_o <= mem[idx];
        end
    end

    // decoder issues a read or a write per transfer, never both at once
    a_no_rw_overlap : assert property (
        @(posedge clk_i) !(!cmd_i.we_n && !cmd_i.re_n)
    ) else $error("mem_bank: read and write enabled in the same cycle");

endmodule

// File: apb_decoder.sv
`timescale 1ns/1ps

// apb front end
// address map: [1:0] byte offset, [WORDS+1:2] word, [WORDS+2] bank, above must be 0

module apb_decoder #(
    parameter int WORDS = 10
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  memsys_pkg::apb_req_t   req_i,
    output memsys_pkg::bank_cmd_t  bank0_cmd_o,
    output memsys_pkg::bank_cmd_t  bank1_cmd_o,
    output memsys_pkg::xfer_info_t info_o
);

    localparam int BANK_BIT = WORDS + 2;            // first bit above the word index

    logic access;                                   // psel and penable
    logic seen_q;                                   // access phase already started
    logic first;                                    // first access cycle
    logic complete;                                 // transfer finishes this cycle
    logic misaligned;
    logic out_of_range;
    logic err;
    logic bank_sel;
    logic go;                                       // valid transfer, issue command
    logic issued;                                   // some bank commanded this cycle

    // ------------------------------------------------------------------------
    // phase tracking
    // ------------------------------------------------------------------------
    assign access = req_i.psel & req_i.penable;
    assign first  = access & ~seen_q;

    // writes and errors end on the first access cycle, reads on the second
    assign complete = (first & (req_i.pwrite | err)) | (access & seen_q);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            seen_q <= 1'b0;
        end else if (complete || !access) begin
            seen_q <= 1'b0;                         // ready for the next setup
        end else if (first) begin
            seen_q <= 1'b1;                         // read waits one more cycle
        end
    end

    // ------------------------------------------------------------------------
    // address checks
    // ------------------------------------------------------------------------
    assign misaligned   = |req_i.paddr[1:0];
    assign out_of_range = |(req_i.paddr >> (BANK_BIT + 1));
    assign err          = misaligned | out_of_range;
    assign bank_sel     = req_i.paddr[BANK_BIT];

    assign go = first & ~err;                       // errors never reach a bank

    // ------------------------------------------------------------------------
    // bank commands
    // ------------------------------------------------------------------------
    // shared fields, only the enables differ
    always_comb begin
        bank0_cmd_o.addr  = req_i.paddr >> 2;       // word index
        bank0_cmd_o.be    = req_i.pstrb;
        bank0_cmd_o.wdata = req_i.pwdata;
        bank0_cmd_o.we_n  = ~(go & req_i.pwrite & ~bank_sel);
        bank0_cmd_o.re_n  = ~(go & ~req_i.pwrite & ~bank_sel);

        bank1_cmd_o       = bank0_cmd_o;
        bank1_cmd_o.we_n  = ~(go & req_i.pwrite & bank_sel);
        bank1_cmd_o.re_n  = ~(go & ~req_i.pwrite & bank_sel);
    end

    // report to the merger
    assign info_o.start = first;
    assign info_o.rd    = ~req_i.pwrite;
    assign info_o.bank  = bank_sel;
    assign info_o.err   = err;

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    assign issued = !bank0_cmd_o.we_n || !bank0_cmd_o.re_n ||
                    !bank1_cmd_o.we_n || !bank1_cmd_o.re_n;

    // one command per transfer, neither bank again in the next cycle
    a_one_bank : assert property (
        @(posedge clk_i) disable iff (rst_i)
        issued |=> !issued
    ) else $error("apb_decoder: banks commanded twice in one transfer");

    // access phase only ever follows a selected setup
    a_penable_psel : assert property (
        @(posedge clk_i) disable iff (rst_i)
        $rose(req_i.penable) |-> req_i.psel
    ) else $error("apb_decoder: penable rose without psel");

endmodule

// File: apb_resp_merge.sv
`timescale 1ns/1ps

// apb completion
// writes and errors answer on start, reads one cycle later from the bank

module apb_resp_merge (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  memsys_pkg::xfer_info_t        info_i,
    input  logic [memsys_pkg::DATA_W-1:0] bank0_data_i,
    input  logic [memsys_pkg::DATA_W-1:0] bank1_data_i,
    output memsys_pkg::apb_rsp_t          rsp_o
);

    logic pend_q;                                   // read issued, data next cycle
    logic bank_q;                                   // bank that owns the read
    logic rd_go;                                    // valid read starting now
    logic fast_done;                                // write or error completes now

    logic [memsys_pkg::DATA_W-1:0] rd_data;

    // ------------------------------------------------------------------------
    // start classification
    // ------------------------------------------------------------------------
    assign rd_go     = info_i.start & info_i.rd & ~info_i.err;
    assign fast_done = info_i.start & (~info_i.rd | info_i.err);

    // ------------------------------------------------------------------------
    // pending read
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_q <= 1'b0;
            bank_q <= 1'b0;
        end else begin
            pend_q <= rd_go;                        // single cycle, never stalls
            if (rd_go) begin
                bank_q <= info_i.bank;
            end
        end
    end

    // ------------------------------------------------------------------------
    // response
    // ------------------------------------------------------------------------
    // bank output is registered, valid the cycle after re_n
    assign rd_data = bank_q ? bank1_data_i : bank0_data_i;

    always_comb begin
        rsp_o.pready  = fast_done | pend_q;
        rsp_o.pslverr = fast_done & info_i.err;     // write completes clean
        rsp_o.prdata  = pend_q ? rd_data : '0;      // zero on writes and errors
    end

    // requester must wait for pready before the next transfer
    a_no_overlap : assert property (
        @(posedge clk_i) disable iff (rst_i)
        pend_q |-> !info_i.start
    ) else $error("apb_resp_merge: new transfer while a read is pending");

endmodule

// File: memsys_top.sv
`timescale 1ns/1ps

// apb memory subsystem
// bank 0 program region, bank 1 data region

module memsys_top #(
    parameter int WORDS = 10                        // each bank holds 2**WORDS words
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  memsys_pkg::apb_req_t apb_i,
    output memsys_pkg::apb_rsp_t apb_o
);

    memsys_pkg::bank_cmd_t  bank0_cmd;
    memsys_pkg::bank_cmd_t  bank1_cmd;
    memsys_pkg::xfer_info_t info;

    logic [memsys_pkg::DATA_W-1:0] bank0_data;
    logic [memsys_pkg::DATA_W-1:0] bank1_data;

    // ------------------------------------------------------------------------
    // front end
    // ------------------------------------------------------------------------
    apb_decoder #(
        .WORDS       (WORDS)
    ) decoder_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (apb_i),
        .bank0_cmd_o (bank0_cmd),
        .bank1_cmd_o (bank1_cmd),
        .info_o      (info)
    );

    // ------------------------------------------------------------------------
    // banks side by side
    // ------------------------------------------------------------------------
    mem_bank #(
        .WORDS  (WORDS)
    ) bank0_i (
        .clk_i  (clk_i),
        .cmd_i  (bank0_cmd),
        .data_o (bank0_data)
    );

    mem_bank #(
        .WORDS  (WORDS)
    ) bank1_i (
        .clk_i  (clk_i),
        .cmd_i  (bank1_cmd),
        .data_o (bank1_data)
    );

    // completion
    apb_resp_merge merge_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .info_i       (info),
        .bank0_data_i (bank0_data),
        .bank1_data_i (bank1_data),
        .rsp_o        (apb_o)
    );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

// clock and reset source for the testbench
// reset held high over the first RST_CYCLES rising edges

module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;    // 50 percent duty
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2;                                         // released off the edge like other inputs
        rst_o = 1'b0;
    end

endmodule

// File: memsys_tb.sv
`timescale 1ns/1ps

// random apb traffic into memsys_top, checked against a 32 word model

module memsys_tb;

    localparam int TB_WORDS   = 4;                  // 16 words per bank
    localparam int BANK_BIT   = TB_WORDS + 2;
    localparam int MODEL_N    = 2 << TB_WORDS;      // both banks
    localparam int DRIVE_DLY  = 2;
    localparam int ACCESS_MAX = 2;                  // access cycles allowed, 3 with setup
    localparam int STRB_N     = 200;
    localparam int INDEP_N    = 16;
    localparam int ERR_N      = 24;

    // ------------------------------------------------------------------------
    // run length and cycle limit
    // ------------------------------------------------------------------------
    localparam int N_XFERS     = 2 * MODEL_N + (STRB_N + MODEL_N) + 3 * INDEP_N + 2 * ERR_N;
    localparam int XFER_BUDGET = 4;                 // idle, setup, two access cycles
    localparam int CYCLE_LIMIT = 4 * (16 + N_XFERS * XFER_BUDGET);

    logic clk;
    logic rst;
    int   cycle_cnt = 0;

    memsys_pkg::apb_req_t apb_req;
    memsys_pkg::apb_rsp_t apb_rsp;

    logic [31:0] model [MODEL_N];                   // word idx = bank * 16 + word

    tb_clk_gen #(
        .PERIOD_NS  (40),
        .RST_CYCLES (5)
    ) clk_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    memsys_top #(
        .WORDS (TB_WORDS)
    ) dut_i (
        .clk_i (clk),
        .rst_i (rst),
        .apb_i (apb_req),
        .apb_o (apb_rsp)
    );

    // hard stop in case a wait never returns
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run went past its limit of %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // byte address of model word idx, bank in the top model bit
    function automatic logic [15:0] word_addr(input int idx);
        return 16'(((idx / 16) << BANK_BIT) | ((idx % 16) << 2));
    endfunction

    function automatic logic [31:0] merge_strobe(input logic [31:0] old_w,
                                                 input logic [31:0] new_w,
                                                 input logic [3:0]  strb);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];   // lane taken only when strobed
        end
        return res;
    endfunction

    // one apb transfer, setup then access until pready, outputs sampled at negedge
    task automatic apb_transfer(input  logic        wr,
                                input  logic [15:0] addr,
                                input  logic [31:0] wdata,
                                input  logic [3:0]  strb,
                                output logic [31:0] rdata,
                                output logic        slverr,
                                output int          cycles);
        logic done;
        done   = 1'b0;
        cycles = 0;
        rdata  = '0;
        slverr = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
        apb_req.psel    = 1'b1;                     // setup
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        apb_req.pstrb   = strb;
        @(posedge clk);
        #DRIVE_DLY;
        apb_req.penable = 1'b1;                     // access
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (apb_rsp.pready) begin
                done   = 1'b1;
                rdata  = apb_rsp.prdata;
                slverr = apb_rsp.pslverr;
            end else begin
                check_value("prdata before pready", 32'd0, apb_rsp.prdata);
                check_value("pslverr before pready", 32'd0, 32'(apb_rsp.pslverr));
                if (cycles >= ACCESS_MAX) begin
                    $display("no pready within %0d cycles of setup at address %h",
                             ACCESS_MAX + 1, addr);
                    $display("TEST RESULT: FAIL");
                    $fatal(1, "transfer timed out");
                end
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
        apb_req.psel    = 1'b0;                     // back to idle
        apb_req.penable = 1'b0;
    endtask

    // transfer plus checks of status, data and latency
    task automatic check_xfer(input string       name,
                              input logic        wr,
                              input logic [15:0] addr,
                              input logic [31:0] wdata,
                              input logic [3:0]  strb,
                              input logic        exp_err,
                              input logic [31:0] exp_rdata);
        logic [31:0] rdata;
        logic        slverr;
        int          cycles;
        apb_transfer(wr, addr, wdata, strb, rdata, slverr, cycles);
        check_value({name, " pslverr"}, 32'(exp_err), 32'(slverr));
        check_value({name, " prdata"}, exp_rdata, rdata);
        check_value({name, " latency"}, (wr || exp_err) ? 32'd1 : 32'd2, 32'(cycles));
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] data;
        logic [3:0]  strb;
        logic [15:0] addr;
        int          idx;
        int          other;
        apb_req = '0;
        void'($urandom(32'hcaf9));
        wait (rst == 1'b0);

        // quiet bus after reset
        repeat (4) begin
            @(negedge clk);
            check_value("reset pready", 32'd0, 32'(apb_rsp.pready));
            check_value("reset pslverr", 32'd0, 32'(apb_rsp.pslverr));
        end

        // fill both banks, then read everything back
        for (int i = 0; i < MODEL_N; i++) begin
            data = $urandom;
            check_xfer("fill write", 1'b1, word_addr(i), data, 4'hf, 1'b0, 32'd0);
            model[i] = data;
        end
        for (int i = 0; i < MODEL_N; i++) begin
            check_xfer("fill read", 1'b0, word_addr(i), 32'd0, 4'h0, 1'b0, model[i]);
        end

        // partial writes, any strobe pattern incl. none
        for (int i = 0; i < STRB_N; i++) begin
            idx  = int'($urandom % MODEL_N);
            data = $urandom;
            strb = 4'($urandom);
            check_xfer("strobe write", 1'b1, word_addr(idx), data, strb, 1'b0, 32'd0);
            model[idx] = merge_strobe(model[idx], data, strb);
        end
        for (int i = 0; i < MODEL_N; i++) begin
            check_xfer("strobe read", 1'b0, word_addr(i), 32'd0, 4'h0, 1'b0, model[i]);
        end

        // same word index, other bank untouched
        for (int i = 0; i < INDEP_N; i++) begin
            idx   = int'($urandom % MODEL_N);
            other = idx ^ 16;                       // flip the bank
            data  = $urandom;
            check_xfer("indep write", 1'b1, word_addr(idx), data, 4'hf, 1'b0, 32'd0);
            model[idx] = data;
            check_xfer("indep other bank", 1'b0, word_addr(other), 32'd0, 4'h0, 1'b0,
                       model[other]);
            check_xfer("indep same bank", 1'b0, word_addr(idx), 32'd0, 4'h0, 1'b0, model[idx]);
        end

        // misaligned or above the bank bit, never touches memory
        for (int i = 0; i < ERR_N; i++) begin
            idx  = int'($urandom % MODEL_N);
            addr = word_addr(idx);
            if ($urandom % 2 == 0) begin
                addr = addr | 16'(1 + $urandom % 3);                  // byte offset 1..3
            end else begin
                addr = addr | 16'((1 + $urandom % 511) << (BANK_BIT + 1));
            end
            data = $urandom;
            check_xfer("error", 1'(($urandom % 2)), addr, data, 4'hf, 1'b1, 32'd0);
            check_xfer("error readback", 1'b0, word_addr(idx), 32'd0, 4'h0, 1'b0, model[idx]);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: memsys.f
memsys_pkg.sv
mem_bank.sv
apb_decoder.sv
apb_resp_merge.sv
memsys_top.sv
tb_clk_gen.sv
memsys_tb.sv

// File: run.sh
#!/bin/sh
# build memsys_tb with verilator and run it
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    --top-module memsys_tb -f memsys.f -o memsys_sim

# a failing run exits nonzero, the log decides the result
./obj_dir/memsys_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
